//--- gamePkg.sv
package gamePkg;
	typedef logic [7:0] xCoord_t; // 0..159
	typedef logic [6:0] yCoord_t; // 0..119
	typedef logic [2:0] colour_t; // one bit each of r, g, b

	// playfield
	localparam int screenWidth = 160;
	localparam int screenHeight = 120;

	// lanes, left edge of each column
	localparam int laneCount = 4;
	typedef logic [$clog2(laneCount)-1:0] laneIdx_t;
	localparam xCoord_t laneX [laneCount] = '{8'd14, 8'd54, 8'd94, 8'd134};

	// object geometry
	localparam yCoord_t playerY = 7'd99; // player never leaves this row
	localparam int objectSize = 10; // player and enemies are square
	localparam int bulletSize = 4;
	localparam int bulletOffset = 3; // roughly centres the bullet on the player
	localparam int bulletStep = 4; // rise per move tick

	// per lane fall speed and colour
	localparam yCoord_t enemyStep [laneCount] = '{7'd4, 7'd2, 7'd3, 7'd1};
	localparam colour_t enemyColour [laneCount] = '{3'd5, 3'd3, 3'd4, 3'd6};
	localparam colour_t playerColour = 3'd7; // white
	localparam colour_t bulletColour = 3'd7;

	// counters
	localparam int healthStart = 3;
	localparam int scoreWidth = 8;
endpackage

//--- renderPkg.sv
package renderPkg;
	// one state per frame phase
	typedef enum logic [2:0] {
		erase, // full screen to black
		drawPlayer,
		drawEnemy, // walks the four lanes
		drawBullet, // skipped when no bullet in flight
		frameDelay,
		update // frame tick
	} renderState_t;

	// what the rectangle mux is pointed at
	typedef enum logic [1:0] {
		objScreen,
		objPlayer,
		objEnemy,
		objBullet
	} drawObject_t;

	localparam int frameDelayCycles = 64; // idle cycles before the move tick
	typedef logic [$clog2(frameDelayCycles)-1:0] delayCount_t;
endpackage

//--- playerLane.sv
`timescale 1ns/1ps

module playerLane import gamePkg::*; (
	input logic clk,
	input logic rstN,
	input logic moveTick,
	input logic moveLeft,
	input logic moveRight,
	output xCoord_t playerX
);
	laneIdx_t lane; // current lane, 0 is leftmost
	logic armed; // keys released since last accepted press
	logic pending; // press waiting for the next move tick
	logic pendRight; // direction of the pending press
	logic onePress;

	assign onePress = moveLeft ^ moveRight; // both held counts as no press
	assign playerX = laneX[lane];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			lane <= '0;
			armed <= 1'b1;
			pending <= 1'b0;
			pendRight <= 1'b0;
		end else begin
			// apply a latched press, clamp at either edge
			if (moveTick && pending) begin
				pending <= 1'b0;
				if (pendRight && lane != laneIdx_t'(laneCount - 1))
					lane <= lane + 1'b1;
				else if (!pendRight && lane != '0)
					lane <= lane - 1'b1;
			end
			// a held key only ever gives one step
			if (!moveLeft && !moveRight)
				armed <= 1'b1;
			else if (onePress && armed) begin
				armed <= 1'b0;
				pending <= 1'b1; // overrides the clear above if same cycle
				pendRight <= moveRight;
			end
		end
	end

	// lane moves at most one step per tick and never wraps
	assert property (@(posedge clk) disable iff (!rstN)
		lane == $past(lane) || int'(lane) == int'($past(lane)) + 1
			|| int'(lane) + 1 == int'($past(lane)));
endmodule

//--- fallingEnemy.sv
`timescale 1ns/1ps

module fallingEnemy import gamePkg::*; #(
	parameter int laneIdx = 0 // selects step, x and colour from the package
) (
	input logic clk,
	input logic rstN,
	input logic moveTick,
	input logic respawn,
	output yCoord_t enemyY
);
	int nextBottom; // bottom edge after one more step

	assign nextBottom = int'(enemyY) + int'(enemyStep[laneIdx]) + objectSize;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			enemyY <= '0; // start at the top
		else if (moveTick) begin
			if (respawn)
				enemyY <= '0; // hit by bullet or player
			else if (nextBottom <= screenHeight)
				enemyY <= enemyY + enemyStep[laneIdx];
			else
				enemyY <= '0; // would leave the screen, wrap
		end
	end
endmodule

//--- bulletTrack.sv
`timescale 1ns/1ps

module bulletTrack import gamePkg::*; (
	input logic clk,
	input logic rstN,
	input logic moveTick,
	input logic fire,
	input logic bulletHit,
	input xCoord_t playerX,
	output logic bulletActive,
	output xCoord_t bulletX,
	output yCoord_t bulletY
);
	// flight state
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			bulletActive <= 1'b0;
		else if (moveTick) begin
			if (!bulletActive)
				bulletActive <= fire;
			else if (bulletHit || bulletY < bulletStep)
				bulletActive <= 1'b0; // hit something or reached the top
		end
	end

	// position, only meaningful while active
	always_ff @(posedge clk) begin
		if (moveTick) begin
			if (!bulletActive) begin
				bulletX <= playerX + xCoord_t'(bulletOffset); // follows the player while idle
				bulletY <= playerY - yCoord_t'(bulletSize); // row just above the player
			end else
				bulletY <= bulletY - yCoord_t'(bulletStep);
		end
	end

	// bullet only ever rises from where it was launched
	assert property (@(posedge clk) disable iff (!rstN)
		bulletActive |-> bulletY <= playerY - yCoord_t'(bulletSize));
endmodule

//--- collisionScore.sv
`timescale 1ns/1ps

module collisionScore import gamePkg::*; (
	input logic clk,
	input logic rstN,
	input logic frameTick,
	input xCoord_t playerX,
	input xCoord_t bulletX,
	input yCoord_t bulletY,
	input logic bulletActive,
	input yCoord_t enemyY0,
	input yCoord_t enemyY1,
	input yCoord_t enemyY2,
	input yCoord_t enemyY3,
	output logic moveTick,
	output logic bulletHit, // retires the bullet
	output logic [laneCount-1:0] respawn, // per lane, bullet or player contact
	output logic [scoreWidth-1:0] score,
	output logic [1:0] health,
	output logic gameOver
);
	yCoord_t enemyYs [laneCount];
	logic [laneCount-1:0] bulletOver, playerOver; // raw overlaps
	logic [laneCount-1:0] bulletHits; // gated to the tick
	logic playerHit;

	// strict overlap of two squares, shared edges do not count
	function automatic logic overlap(input int ax, input int ay, input int aSize,
			input int bx, input int by, input int bSize);
		return (ax < bx + bSize) && (bx < ax + aSize) && (ay < by + bSize) && (by < ay + aSize);
	endfunction

	assign enemyYs = '{enemyY0, enemyY1, enemyY2, enemyY3};

	always_comb begin
		for (int k = 0; k < laneCount; k++) begin
			bulletOver[k] = bulletActive &&
				overlap(bulletX, bulletY, bulletSize, laneX[k], enemyYs[k], objectSize);
			playerOver[k] = overlap(playerX, playerY, objectSize, laneX[k], enemyYs[k], objectSize);
		end
	end

	assign gameOver = (health == 2'd0);
	assign moveTick = frameTick && !gameOver; // everything freezes once dead
	assign bulletHits = bulletOver & {laneCount{moveTick}};
	assign bulletHit = |bulletHits;
	assign playerHit = moveTick && |playerOver;
	assign respawn = (bulletOver | playerOver) & {laneCount{moveTick}};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			score <= '0;
			health <= 2'(healthStart);
		end else begin
			score <= score + scoreWidth'($countones(bulletHits));
			if (playerHit)
				health <= health - 2'd1; // never underflows, hits stop at zero
		end
	end

	// health only goes down
	assert property (@(posedge clk) disable iff (!rstN) health <= $past(health));
endmodule

//--- frameSequencer.sv
`timescale 1ns/1ps

module frameSequencer import gamePkg::*, renderPkg::*; (
	input logic clk,
	input logic rstN,
	input logic rectDone,
	input logic bulletActive,
	input xCoord_t playerX,
	input xCoord_t bulletX,
	input yCoord_t bulletY,
	input yCoord_t enemyY0,
	input yCoord_t enemyY1,
	input yCoord_t enemyY2,
	input yCoord_t enemyY3,
	output logic rectStart,
	output xCoord_t rectX,
	output yCoord_t rectY,
	output xCoord_t rectWidth,
	output yCoord_t rectHeight,
	output colour_t rectColour,
	output logic frameTick
);
	renderState_t state;
	drawObject_t curObject;
	laneIdx_t enemyIdx; // which lane during drawEnemy
	delayCount_t delayCnt;
	logic launch; // start the rectangle of the state just entered
	yCoord_t enemyYs [laneCount];

	assign enemyYs = '{enemyY0, enemyY1, enemyY2, enemyY3};
	assign rectStart = launch;
	assign frameTick = (state == update);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= erase;
			launch <= 1'b1; // first erase begins right away
			enemyIdx <= '0;
			delayCnt <= '0;
		end else begin
			launch <= 1'b0;
			case (state)
				erase: if (rectDone) begin
					state <= drawPlayer;
					launch <= 1'b1;
				end
				drawPlayer: if (rectDone) begin
					state <= drawEnemy;
					launch <= 1'b1;
				end
				drawEnemy: if (rectDone) begin
					launch <= 1'b1;
					if (enemyIdx == laneIdx_t'(laneCount - 1)) begin
						enemyIdx <= '0;
						state <= bulletActive ? drawBullet : frameDelay;
						launch <= bulletActive; // no bullet, go straight to the delay
					end else
						enemyIdx <= enemyIdx + 1'b1;
				end
				drawBullet: if (rectDone)
					state <= frameDelay;
				frameDelay: begin
					if (delayCnt == delayCount_t'(frameDelayCycles - 1)) begin
						delayCnt <= '0;
						state <= update;
					end else
						delayCnt <= delayCnt + 1'b1;
				end
				default: begin // update lasts one cycle
					state <= erase;
					launch <= 1'b1;
				end
			endcase
		end
	end

	always_comb begin
		case (state)
			drawPlayer: curObject = objPlayer;
			drawEnemy: curObject = objEnemy;
			drawBullet: curObject = objBullet;
			default: curObject = objScreen;
		endcase
	end

	// rectangle mux, stable for the whole scan since movers wait for the tick
	always_comb begin
		rectX = '0;
		rectY = '0;
		rectWidth = xCoord_t'(objectSize);
		rectHeight = yCoord_t'(objectSize);
		rectColour = '0; // black for erase
		case (curObject)
			objPlayer: begin
				rectX = playerX;
				rectY = playerY;
				rectColour = playerColour;
			end
			objEnemy: begin
				rectX = laneX[enemyIdx];
				rectY = enemyYs[enemyIdx];
				rectColour = enemyColour[enemyIdx];
			end
			objBullet: begin
				rectX = bulletX;
				rectY = bulletY;
				rectWidth = xCoord_t'(bulletSize);
				rectHeight = yCoord_t'(bulletSize);
				rectColour = bulletColour;
			end
			default: begin // whole screen
				rectWidth = xCoord_t'(screenWidth);
				rectHeight = yCoord_t'(screenHeight);
			end
		endcase
	end

	// move tick is a single pulse per frame
	assert property (@(posedge clk) disable iff (!rstN) frameTick |=> !frameTick);
endmodule

//--- rectRaster.sv
`timescale 1ns/1ps

module rectRaster import gamePkg::*; (
	input logic clk,
	input logic rstN,
	input logic rectStart,
	input xCoord_t rectX,
	input yCoord_t rectY,
	input xCoord_t rectWidth,
	input yCoord_t rectHeight,
	input colour_t rectColour,
	output xCoord_t pixelX,
	output yCoord_t pixelY,
	output colour_t pixelColour,
	output logic pixelPlot,
	output logic rectDone
);
	xCoord_t baseX, sizeW, col; // latched origin and width, column counter
	yCoord_t baseY, sizeH, row;
	colour_t colour;
	logic busy; // scan in progress
	logic lastCol;

	assign lastCol = (col == sizeW - 8'd1);
	assign rectDone = busy && lastCol && (row == sizeH - 7'd1); // with the last pixel
	assign pixelPlot = busy;
	assign pixelX = baseX + col;
	assign pixelY = baseY + row;
	assign pixelColour = colour;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (rectStart) begin
			busy <= 1'b1; // first pixel next cycle
			col <= '0;
			row <= '0;
		end else if (busy) begin
			if (rectDone)
				busy <= 1'b0;
			else if (lastCol) begin
				col <= '0; // next row
				row <= row + 7'd1;
			end else
				col <= col + 8'd1;
		end
	end

	// rectangle held for the whole scan
	always_ff @(posedge clk) begin
		if (rectStart) begin
			baseX <= rectX;
			baseY <= rectY;
			sizeW <= rectWidth;
			sizeH <= rectHeight;
			colour <= rectColour;
		end
	end

	// sequencer must wait for rectDone
	assert property (@(posedge clk) disable iff (!rstN) rectStart |-> !busy);
endmodule

//--- shooterTop.sv
`timescale 1ns/1ps

module shooterTop import gamePkg::*; (
	input logic clk,
	input logic rstN,
	input logic moveLeft,
	input logic moveRight,
	input logic fire,
	output xCoord_t pixelX,
	output yCoord_t pixelY,
	output colour_t pixelColour,
	output logic pixelPlot,
	output logic frameTick,
	output logic [scoreWidth-1:0] score,
	output logic [1:0] health,
	output logic gameOver
);
	logic moveTick; // frame tick, stopped at game over
	logic bulletActive, bulletHit;
	logic [laneCount-1:0] respawn;
	xCoord_t playerX, bulletX;
	yCoord_t bulletY;
	yCoord_t enemyY [laneCount];
	logic rectStart, rectDone; // sequencer to raster
	xCoord_t rectX, rectWidth;
	yCoord_t rectY, rectHeight;
	colour_t rectColour;

	playerLane player (
		.clk(clk), .rstN(rstN), .moveTick(moveTick),
		.moveLeft(moveLeft), .moveRight(moveRight), .playerX(playerX));

	// one enemy per lane
	for (genvar k = 0; k < laneCount; k++) begin : genEnemy
		fallingEnemy #(.laneIdx(k)) enemy (
			.clk(clk), .rstN(rstN), .moveTick(moveTick),
			.respawn(respawn[k]), .enemyY(enemyY[k]));
	end

	bulletTrack bullet (
		.clk(clk), .rstN(rstN), .moveTick(moveTick), .fire(fire), .bulletHit(bulletHit),
		.playerX(playerX), .bulletActive(bulletActive), .bulletX(bulletX), .bulletY(bulletY));

	collisionScore collide (
		.clk(clk), .rstN(rstN), .frameTick(frameTick), .playerX(playerX),
		.bulletX(bulletX), .bulletY(bulletY), .bulletActive(bulletActive),
		.enemyY0(enemyY[0]), .enemyY1(enemyY[1]), .enemyY2(enemyY[2]), .enemyY3(enemyY[3]),
		.moveTick(moveTick), .bulletHit(bulletHit), .respawn(respawn),
		.score(score), .health(health), .gameOver(gameOver));

	frameSequencer sequencer (
		.clk(clk), .rstN(rstN), .rectDone(rectDone), .bulletActive(bulletActive),
		.playerX(playerX), .bulletX(bulletX), .bulletY(bulletY),
		.enemyY0(enemyY[0]), .enemyY1(enemyY[1]), .enemyY2(enemyY[2]), .enemyY3(enemyY[3]),
		.rectStart(rectStart), .rectX(rectX), .rectY(rectY), .rectWidth(rectWidth),
		.rectHeight(rectHeight), .rectColour(rectColour), .frameTick(frameTick));

	rectRaster raster (
		.clk(clk), .rstN(rstN), .rectStart(rectStart), .rectX(rectX), .rectY(rectY),
		.rectWidth(rectWidth), .rectHeight(rectHeight), .rectColour(rectColour),
		.pixelX(pixelX), .pixelY(pixelY), .pixelColour(pixelColour),
		.pixelPlot(pixelPlot), .rectDone(rectDone));
endmodule

//--- tbShooter.sv
`timescale 1ns/1ps

module tbShooter import gamePkg::*; ();
	localparam int frameTimeout = 25000; // one frame is about 19.8k cycles

	logic clk, rstN, moveLeft, moveRight, fire;
	xCoord_t pixelX;
	yCoord_t pixelY;
	colour_t pixelColour;
	logic pixelPlot, frameTick, gameOver;
	logic [scoreWidth-1:0] score;
	logic [1:0] health;

	int mismatchCount, failureCount;
	logic timedOut; // a frame tick went missing
	// reference game state, as drawn in the current frame
	int mLane, mEnemyY [laneCount], mBulletX, mBulletY, mScore, mHealth;
	logic mArmed, mPending, mPendRight, mBulletActive;
	// expected pixel walker
	int sIdx, sCol, sRow, rectCount;
	int rx, ry, rw, rh, rc, expX, expY;

	shooterTop UUT (.*);

	always #5 clk = ~clk;

	// two squares share area, touching edges do not count
	function automatic logic boxesTouch(input int ax, input int ay, input int aSize,
			input int bx, input int by, input int bSize);
		return !(ax + aSize <= bx || bx + bSize <= ax || ay + aSize <= by || by + bSize <= ay);
	endfunction

	always @(posedge clk or negedge rstN) begin : refModel
		int px, hits;
		logic [laneCount-1:0] bOver, pOver;
		if (!rstN) begin
			mLane <= 0;
			mArmed <= 1'b1;
			mPending <= 1'b0;
			mPendRight <= 1'b0;
			for (int k = 0; k < laneCount; k++)
				mEnemyY[k] <= 0;
			mBulletActive <= 1'b0;
			mBulletX <= 0;
			mBulletY <= 0;
			mScore <= 0;
			mHealth <= healthStart;
		end else begin
			px = int'(laneX[mLane]);
			hits = 0;
			for (int k = 0; k < laneCount; k++) begin
				bOver[k] = mBulletActive && boxesTouch(mBulletX, mBulletY, bulletSize,
					int'(laneX[k]), mEnemyY[k], objectSize);
				pOver[k] = boxesTouch(px, int'(playerY), objectSize,
					int'(laneX[k]), mEnemyY[k], objectSize);
				hits += int'(bOver[k]);
			end
			if (frameTick && mHealth != 0) begin // frozen once health is gone
				for (int k = 0; k < laneCount; k++) begin
					if (bOver[k] || pOver[k])
						mEnemyY[k] <= 0; // back to the top
					else if (mEnemyY[k] + int'(enemyStep[k]) + objectSize <= screenHeight)
						mEnemyY[k] <= mEnemyY[k] + int'(enemyStep[k]);
					else
						mEnemyY[k] <= 0; // wrap
				end
				if (!mBulletActive) begin
					mBulletActive <= fire;
					mBulletX <= px + bulletOffset; // launch from old lane
					mBulletY <= int'(playerY) - bulletSize;
				end else if (bOver != '0 || mBulletY < bulletStep)
					mBulletActive <= 1'b0;
				else
					mBulletY <= mBulletY - bulletStep;
				if (mPending) begin
					mPending <= 1'b0;
					if (mPendRight && mLane < laneCount - 1)
						mLane <= mLane + 1;
					else if (!mPendRight && mLane > 0)
						mLane <= mLane - 1;
				end
				mScore <= mScore + hits;
				if (pOver != '0)
					mHealth <= mHealth - 1;
			end
			// key latch, one step per press
			if (!moveLeft && !moveRight)
				mArmed <= 1'b1;
			else if ((moveLeft ^ moveRight) && mArmed) begin
				mArmed <= 1'b0;
				mPending <= 1'b1;
				mPendRight <= moveRight;
			end
		end
	end

	// rectangle under the walker: erase, player, 4 enemies, bullet
	always_comb begin
		rectCount = mBulletActive ? 7 : 6;
		rx = 0;
		ry = 0;
		rw = objectSize;
		rh = objectSize;
		rc = 0;
		case (sIdx)
			0: begin
				rw = screenWidth;
				rh = screenHeight;
			end
			1: begin
				rx = int'(laneX[mLane]);
				ry = int'(playerY);
				rc = int'(playerColour);
			end
			2, 3, 4, 5: begin
				rx = int'(laneX[sIdx - 2]);
				ry = mEnemyY[sIdx - 2];
				rc = int'(enemyColour[sIdx - 2]);
			end
			default: begin
				rx = mBulletX;
				ry = mBulletY;
				rw = bulletSize;
				rh = bulletSize;
				rc = int'(bulletColour);
			end
		endcase
		expX = rx + sCol;
		expY = ry + sRow;
	end

	always @(posedge clk or negedge rstN) begin : pixelWalk
		if (!rstN || frameTick) begin // new frame starts with the erase
			sIdx <= 0;
			sCol <= 0;
			sRow <= 0;
		end else if (pixelPlot) begin
			if (sCol == rw - 1) begin
				sCol <= 0;
				if (sRow == rh - 1) begin
					sRow <= 0;
					sIdx <= sIdx + 1;
				end else
					sRow <= sRow + 1;
			end else
				sCol <= sCol + 1;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) pixelPlot |-> sIdx < rectCount)
		else begin
			failureCount++;
			$display("pixel plotted after the last rectangle of the frame at %0t", $time);
		end
	assert property (@(posedge clk) disable iff (!rstN) frameTick |-> sIdx == rectCount)
		else begin
			failureCount++;
			$display("frame tick at %0t came before all rectangles were drawn", $time);
		end
	assert property (@(posedge clk) disable iff (!rstN)
			pixelPlot && sIdx < rectCount |-> int'(pixelX) == expX)
		else begin
			mismatchCount++;
			$display("MISMATCH %0t pixelX got %0d expected %0d", $time, $sampled(pixelX),
				$sampled(expX));
		end
	assert property (@(posedge clk) disable iff (!rstN)
			pixelPlot && sIdx < rectCount |-> int'(pixelY) == expY)
		else begin
			mismatchCount++;
			$display("MISMATCH %0t pixelY got %0d expected %0d", $time, $sampled(pixelY),
				$sampled(expY));
		end
	assert property (@(posedge clk) disable iff (!rstN)
			pixelPlot && sIdx < rectCount |-> int'(pixelColour) == rc)
		else begin
			mismatchCount++;
			$display("MISMATCH %0t pixelColour got %0d expected %0d", $time,
				$sampled(pixelColour), $sampled(rc));
		end
	assert property (@(posedge clk) disable iff (!rstN) int'(score) == mScore)
		else begin
			mismatchCount++;
			$display("MISMATCH %0t score got %0d expected %0d", $time, $sampled(score),
				$sampled(mScore));
		end
	assert property (@(posedge clk) disable iff (!rstN) int'(health) == mHealth)
		else begin
			mismatchCount++;
			$display("MISMATCH %0t health got %0d expected %0d", $time, $sampled(health),
				$sampled(mHealth));
		end
	assert property (@(posedge clk) disable iff (!rstN) gameOver == (mHealth == 0))
		else begin
			mismatchCount++;
			$display("MISMATCH %0t gameOver got %0b expected %0b", $time, $sampled(gameOver),
				$sampled(mHealth == 0));
		end

	task automatic endRun();
		$display("error counts: %0d mismatches, %0d other failures", mismatchCount,
			failureCount);
		if (mismatchCount == 0 && failureCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#1;
		end
	endtask

	// returns one cycle after the tick edge, at once after a lost tick
	task automatic waitFrame();
		int cycles;
		cycles = 0;
		if (!timedOut) begin
			do begin
				@(posedge clk);
				#1;
				cycles++;
			end while (!frameTick && cycles < frameTimeout);
			if (!frameTick) begin
				failureCount++;
				timedOut = 1'b1;
				$display("no frame tick within %0d cycles at %0t", frameTimeout, $time);
			end else begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	task automatic pressKey(input logic right);
		idle($urandom_range(12000, 1)); // somewhere inside the frame
		moveRight = right;
		moveLeft = !right;
		idle($urandom_range(400, 1));
		moveRight = 1'b0;
		moveLeft = 1'b0;
		waitFrame();
	endtask

	task automatic fireOnce();
		idle($urandom_range(12000, 1));
		fire = 1'b1; // held through the tick
		waitFrame();
		fire = 1'b0;
	endtask

	initial begin
		int frames;
		clk = 1'b0;
		rstN = 1'b0;
		moveLeft = 1'b0;
		moveRight = 1'b0;
		fire = 1'b0;
		mismatchCount = 0;
		failureCount = 0;
		timedOut = 1'b0;
		void'($urandom(32'h8ac0c78d));
		repeat (4) @(posedge clk);
		#1 rstN = 1'b1;
		repeat (2) waitFrame();
		repeat (4) pressKey(1'b1); // last one clamps at lane 3
		moveLeft = 1'b1; // held over three ticks, one step only
		repeat (3) waitFrame();
		moveLeft = 1'b0;
		repeat (3) pressKey(1'b0); // ends clamped at lane 0
		for (int lane = 0; lane < laneCount; lane++) begin
			fireOnce();
			repeat (24) waitFrame(); // bullet flight
			pressKey(1'b1);
		end
		repeat (3) pressKey(1'b0);
		frames = 0;
		while (!gameOver && !timedOut && frames < 200) begin // enemy 0 keeps landing on the player
			waitFrame();
			frames++;
		end
		if (gameOver) begin
			pressKey(1'b1); // ignored while frozen
			fireOnce();
			repeat (2) waitFrame();
		end else if (!timedOut) begin
			failureCount++;
			$display("game did not end within %0d frames", frames);
		end
		endRun();
	end
endmodule

//--- build.f
gamePkg.sv
renderPkg.sv
playerLane.sv
fallingEnemy.sv
bulletTrack.sv
collisionScore.sv
frameSequencer.sv
rectRaster.sv
shooterTop.sv
tbShooter.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the shooter testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tbShooter -o simShooter; then
	echo "Verilator build failed"
	exit 1
fi

simOutput=$(./obj_dir/simShooter)
simStatus=$?
echo "$simOutput"
if [ "$simStatus" -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi
if grep -qx "Testbench passed" <<< "$simOutput"; then
	exit 0
fi
exit 1
